// File: rtl/rv32i_isa_pkg.sv
`default_nettype none

package rv32i_isa_pkg;

  // major opcodes handled by the integer ALU slice
  localparam logic [6:0] lui_opcode   = 7'b0110111;
  localparam logic [6:0] auipc_opcode = 7'b0010111;
  localparam logic [6:0] imm_opcode   = 7'b0010011;
  localparam logic [6:0] reg_opcode   = 7'b0110011;

  // funct3 for OP and OP-IMM
  localparam logic [2:0] add_funct3  = 3'b000;
  localparam logic [2:0] sll_funct3  = 3'b001;
  localparam logic [2:0] slt_funct3  = 3'b010;
  localparam logic [2:0] sltu_funct3 = 3'b011;
  localparam logic [2:0] xor_funct3  = 3'b100;
  localparam logic [2:0] sr_funct3   = 3'b101;
  localparam logic [2:0] or_funct3   = 3'b110;
  localparam logic [2:0] and_funct3  = 3'b111;

  // datapath operations
  typedef enum logic [3:0] {
    add_alu_op  = 4'd0,
    sub_alu_op  = 4'd1,
    sll_alu_op  = 4'd2,
    slt_alu_op  = 4'd3,
    sltu_alu_op = 4'd4,
    xor_alu_op  = 4'd5,
    srl_alu_op  = 4'd6,
    sra_alu_op  = 4'd7,
    or_alu_op   = 4'd8,
    and_alu_op  = 4'd9
  } alu_op_t;

  // register form, also used for funct3 / funct7 of OP-IMM
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_view_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_view_t;

  // one instruction word, decoded per format
  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
    u_view_t u_view;
  } instr_u;

endpackage

`default_nettype wire

// File: rtl/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  localparam int rob_tag_w = 4;

  typedef logic [rob_tag_w-1:0] rob_tag_t;

  // one source operand as reported by the register file or the ROB
  typedef struct packed {
    logic        ready;
    logic [31:0] value;
    rob_tag_t    tag;
  } src_t;

  // dispatched instruction with both views of its sources
  typedef struct packed {
    rv32i_isa_pkg::instr_u instr;
    logic [31:0]           pc;
    rob_tag_t              target;
    src_t                  rs1_rf;
    src_t                  rs2_rf;
    src_t                  rs1_rob;
    src_t                  rs2_rob;
  } issue_t;

  // single CDB port
  typedef struct packed {
    logic        valid;
    rob_tag_t    tag;
    logic [31:0] value;
  } cdb_t;

  // entry handed from the station to execute
  typedef struct packed {
    rv32i_isa_pkg::instr_u instr;
    logic [31:0]           rs1_value;
    logic [31:0]           rs2_value;
    rob_tag_t              target;
  } exec_req_t;

endpackage

`default_nettype wire

// File: rtl/alu_rs.sv
`timescale 1ns/100ps
`default_nettype none

module alu_rs #(
  parameter int rs_depth = 3,
  parameter int cdb_size = 2
) (
  input  wire                clk,
  input  wire                rst,
  input  wire                issue_valid,
  input  wire ooo_pkg::issue_t issue,
  input  wire ooo_pkg::cdb_t cdb_in [cdb_size],
  output logic               full,
  output logic               sel_valid,
  output ooo_pkg::exec_req_t sel
);

  localparam int n_entries = 2 ** rs_depth;

  // stored state of one waiting instruction
  typedef struct packed {
    rv32i_isa_pkg::instr_u instr;
    ooo_pkg::src_t         rs1;
    ooo_pkg::src_t         rs2;
    ooo_pkg::rob_tag_t     target;
  } entry_t;

  logic [n_entries-1:0] busy;
  entry_t               entries [n_entries];

  // rotating select pointer
  logic [rs_depth-1:0] ptr;

  logic                have_free;
  logic [rs_depth-1:0] free_idx;
  logic [n_entries-1:0] ready;
  logic [rs_depth-1:0] sel_idx;

  logic [31:0]   u_imm;
  logic [31:0]   i_imm;
  ooo_pkg::src_t rs1_cap;
  ooo_pkg::src_t rs2_cap;

  // regfile first, then ROB, then a same-cycle CDB hit on the regfile tag
  function automatic ooo_pkg::src_t resolve(ooo_pkg::src_t rf, ooo_pkg::src_t rob);
    ooo_pkg::src_t res;
    res = rf;
    if (!rf.ready) begin
      if (rob.ready) begin
        res.ready = 1'b1;
        res.value = rob.value;
      end else begin
        for (int j = 0; j < cdb_size; j++) begin
          if (cdb_in[j].valid && (cdb_in[j].tag == rf.tag)) begin
            res.ready = 1'b1;
            res.value = cdb_in[j].value;
          end
        end
      end
    end
    return res;
  endfunction

  // operand capture for the incoming instruction
  always_comb begin
    u_imm = {issue.instr.u_view.imm20, 12'h000};
    i_imm = {{20{issue.instr.i_view.imm12[11]}}, issue.instr.i_view.imm12};
    rs1_cap = resolve(issue.rs1_rf, issue.rs1_rob);
    rs2_cap = resolve(issue.rs2_rf, issue.rs2_rob);
    case (issue.instr.r_view.opcode)
      rv32i_isa_pkg::lui_opcode: begin
        rs1_cap = '{ready: 1'b1, value: 32'h0, tag: '0};
        rs2_cap = '{ready: 1'b1, value: u_imm, tag: '0};
      end
      rv32i_isa_pkg::auipc_opcode: begin
        rs1_cap = '{ready: 1'b1, value: issue.pc, tag: '0};
        rs2_cap = '{ready: 1'b1, value: u_imm, tag: '0};
      end
      rv32i_isa_pkg::imm_opcode: begin
        rs2_cap = '{ready: 1'b1, value: i_imm, tag: '0};
      end
      default: begin
        // register form keeps both resolved sources
      end
    endcase
  end

  // lowest free entry
  always_comb begin
    have_free = 1'b0;
    free_idx  = '0;
    for (int i = n_entries - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        have_free = 1'b1;
        free_idx  = rs_depth'(i);
      end
    end
  end

  assign full = ~have_free;

  always_comb begin
    for (int i = 0; i < n_entries; i++) begin
      ready[i] = busy[i] & entries[i].rs1.ready & entries[i].rs2.ready;
    end
  end

  // first ready entry at or after ptr, wrapping
  always_comb begin
    logic [rs_depth-1:0] idx;
    sel_valid = 1'b0;
    sel_idx   = ptr;
    for (int k = n_entries - 1; k >= 0; k--) begin
      idx = ptr + rs_depth'(k);
      if (ready[idx]) begin
        sel_valid = 1'b1;
        sel_idx   = idx;
      end
    end
  end

  assign sel = '{
    instr:     entries[sel_idx].instr,
    rs1_value: entries[sel_idx].rs1.value,
    rs2_value: entries[sel_idx].rs2.value,
    target:    entries[sel_idx].target
  };

  // occupancy and pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
      ptr  <= '0;
    end else begin
      if (issue_valid && have_free) begin
        busy[free_idx] <= 1'b1;
      end
      // selected entry leaves the station at this edge
      if (sel_valid) begin
        busy[sel_idx] <= 1'b0;
        ptr           <= sel_idx + 1'b1;
      end
    end
  end

  // entry payload, issue capture and CDB wakeup
  always_ff @(posedge clk) begin
    for (int i = 0; i < n_entries; i++) begin
      if (busy[i]) begin
        for (int j = 0; j < cdb_size; j++) begin
          if (cdb_in[j].valid && !entries[i].rs1.ready &&
              (cdb_in[j].tag == entries[i].rs1.tag)) begin
            entries[i].rs1.ready <= 1'b1;
            entries[i].rs1.value <= cdb_in[j].value;
          end
          if (cdb_in[j].valid && !entries[i].rs2.ready &&
              (cdb_in[j].tag == entries[i].rs2.tag)) begin
            entries[i].rs2.ready <= 1'b1;
            entries[i].rs2.value <= cdb_in[j].value;
          end
        end
      end
    end
    // issue only writes a free entry, wakeup only busy ones
    if (issue_valid && have_free) begin
      entries[free_idx] <= '{
        instr:  issue.instr,
        rs1:    rs1_cap,
        rs2:    rs2_cap,
        target: issue.target
      };
    end
  end

endmodule

`default_nettype wire

// File: rtl/alu_exec.sv
`timescale 1ns/100ps
`default_nettype none

module alu_exec (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   sel_valid,
  input  wire ooo_pkg::exec_req_t sel,
  output ooo_pkg::cdb_t         result
);

  rv32i_isa_pkg::alu_op_t op;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic        alt;
  logic        is_reg;
  logic [31:0] a;
  logic [31:0] b;
  logic [4:0]  shamt;
  logic [31:0] f;

  assign opcode = sel.instr.r_view.opcode;
  assign funct3 = sel.instr.r_view.funct3;
  // bit 30, also the srai marker in the I form
  assign alt    = sel.instr.r_view.funct7[5];
  assign is_reg = (opcode == rv32i_isa_pkg::reg_opcode);

  assign a     = sel.rs1_value;
  assign b     = sel.rs2_value;
  assign shamt = b[4:0];

  // operation decode
  always_comb begin
    op = rv32i_isa_pkg::add_alu_op;
    if (is_reg || (opcode == rv32i_isa_pkg::imm_opcode)) begin
      case (funct3)
        rv32i_isa_pkg::add_funct3: begin
          // sub only in register form
          op = (is_reg && alt) ? rv32i_isa_pkg::sub_alu_op : rv32i_isa_pkg::add_alu_op;
        end
        rv32i_isa_pkg::sll_funct3:  op = rv32i_isa_pkg::sll_alu_op;
        rv32i_isa_pkg::slt_funct3:  op = rv32i_isa_pkg::slt_alu_op;
        rv32i_isa_pkg::sltu_funct3: op = rv32i_isa_pkg::sltu_alu_op;
        rv32i_isa_pkg::xor_funct3:  op = rv32i_isa_pkg::xor_alu_op;
        rv32i_isa_pkg::sr_funct3: begin
          op = alt ? rv32i_isa_pkg::sra_alu_op : rv32i_isa_pkg::srl_alu_op;
        end
        rv32i_isa_pkg::or_funct3:   op = rv32i_isa_pkg::or_alu_op;
        default:                    op = rv32i_isa_pkg::and_alu_op;
      endcase
    end
    // lui and auipc fall through as add
  end

  // datapath, comparator folded in for set-less-than
  always_comb begin
    case (op)
      rv32i_isa_pkg::add_alu_op:  f = a + b;
      rv32i_isa_pkg::sub_alu_op:  f = a - b;
      rv32i_isa_pkg::sll_alu_op:  f = a << shamt;
      rv32i_isa_pkg::slt_alu_op:  f = {31'b0, ($signed(a) < $signed(b))};
      rv32i_isa_pkg::sltu_alu_op: f = {31'b0, (a < b)};
      rv32i_isa_pkg::xor_alu_op:  f = a ^ b;
      rv32i_isa_pkg::srl_alu_op:  f = a >> shamt;
      rv32i_isa_pkg::sra_alu_op:  f = $signed(a) >>> shamt;
      rv32i_isa_pkg::or_alu_op:   f = a | b;
      rv32i_isa_pkg::and_alu_op:  f = a & b;
      default:                    f = a + b;
    endcase
  end

  // CDB output register, one-cycle valid pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= sel_valid;
      if (sel_valid) begin
        result.tag   <= sel.target;
        result.value <= f;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit #(
  parameter int rs_depth = 3,
  parameter int cdb_size = 2
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  issue_valid,
  input  wire ooo_pkg::issue_t issue,
  input  wire ooo_pkg::cdb_t   cdb_in [cdb_size],
  output logic                 full,
  output ooo_pkg::cdb_t        result
);

  // station to execute
  logic               sel_valid;
  ooo_pkg::exec_req_t sel;

  alu_rs #(
    .rs_depth (rs_depth),
    .cdb_size (cdb_size)
  ) alu_rs_i (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue       (issue),
    .cdb_in      (cdb_in),
    .full        (full),
    .sel_valid   (sel_valid),
    .sel         (sel)
  );

  alu_exec alu_exec_i (
    .clk       (clk),
    .rst       (rst),
    .sel_valid (sel_valid),
    .sel       (sel),
    .result    (result)
  );

endmodule

`default_nettype wire

// File: verif/alu_unit_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit_assertions #(
  parameter int rs_depth = 3
) (
  input wire                   clk,
  input wire                   rst,
  input wire                   issue_valid,
  input wire                   full,
  input wire                   sel_valid,
  input wire [2**rs_depth-1:0] busy
);

  localparam int n_entries = 2 ** rs_depth;

  logic              accepted;
  // entries held, counted from accepted issues and selections
  logic [rs_depth:0] occ;

  assign accepted = issue_valid && !full;

  always_ff @(posedge clk) begin
    if (rst) begin
      occ <= '0;
    end else if (accepted && !sel_valid) begin
      occ <= occ + 1'b1;
    end else if (sel_valid && !accepted) begin
      occ <= occ - 1'b1;
    end
  end

  // dispatch holds off while the station is full
  no_issue_when_full: assert property (
    @(posedge clk) disable iff (rst) !(issue_valid && full)
  ) else $error("issue_valid high while full is high");

  // station is empty right after reset
  idle_after_reset: assert property (
    @(posedge clk) rst |=> (!full && !sel_valid)
  ) else $error("full or sel_valid high in the cycle after reset");

  // busy bits follow the issue and select history within capacity
  occupancy_in_range: assert property (
    @(posedge clk) disable iff (rst)
      (occ <= n_entries) && ($countones(busy) == occ)
  ) else $error("occupied entries disagree with issues and selections");

endmodule

bind alu_rs alu_unit_assertions #(
  .rs_depth (rs_depth)
) alu_unit_assertions_i (
  .clk         (clk),
  .rst         (rst),
  .issue_valid (issue_valid),
  .full        (full),
  .sel_valid   (sel_valid),
  .busy        (busy)
);

`default_nettype wire

// File: verif/alu_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit_tb;

  localparam int rs_depth   = 3;
  localparam int cdb_size   = 2;
  localparam int n_entries  = 2 ** rs_depth;
  localparam int wait_limit = 200;

  logic            clk;
  logic            rst;
  logic            issue_valid;
  ooo_pkg::issue_t issue;
  ooo_pkg::cdb_t   cdb_in [cdb_size];
  logic            full;
  ooo_pkg::cdb_t   result;

  // scoreboard by target tag (0..7)
  logic [15:0] pending;
  logic [31:0] exp_val  [16];
  // producer values by waiting tag (8..15)
  logic [31:0] prod_val [16];

  alu_unit #(
    .rs_depth (rs_depth),
    .cdb_size (cdb_size)
  ) alu_unit_i (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue       (issue),
    .cdb_in      (cdb_in),
    .full        (full),
    .result      (result)
  );

  always #2 clk = ~clk;

  task automatic check(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_timeout(string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  function automatic ooo_pkg::src_t make_src(logic ready, logic [31:0] value, logic [3:0] tag);
    ooo_pkg::src_t s;
    s.ready = ready;
    s.value = value;
    s.tag   = tag;
    return s;
  endfunction

  function automatic ooo_pkg::cdb_t bcast(logic [3:0] tag);
    ooo_pkg::cdb_t c;
    c.valid = 1'b1;
    c.tag   = tag;
    c.value = prod_val[tag];
    return c;
  endfunction

  // regfile value before ROB value before broadcast value
  function automatic logic [31:0] operand(ooo_pkg::src_t rf, ooo_pkg::src_t rob);
    if (rf.ready) return rf.value;
    if (rob.ready) return rob.value;
    return prod_val[rf.tag];
  endfunction

  // RV32I reference result
  function automatic logic [31:0] model(logic [31:0] word, logic [31:0] pc,
                                        logic [31:0] a, logic [31:0] b);
    logic [31:0] u_imm;
    logic [31:0] op2;
    logic        is_reg;
    u_imm  = {word[31:12], 12'h000};
    is_reg = (word[6:0] == rv32i_isa_pkg::reg_opcode);
    op2    = is_reg ? b : {{20{word[31]}}, word[31:20]};
    if (word[6:0] == rv32i_isa_pkg::lui_opcode) return u_imm;
    if (word[6:0] == rv32i_isa_pkg::auipc_opcode) return pc + u_imm;
    case (word[14:12])
      3'd0: return (is_reg && word[30]) ? a - op2 : a + op2;
      3'd1: return a << op2[4:0];
      3'd2: return ($signed(a) < $signed(op2)) ? 32'd1 : 32'd0;
      3'd3: return (a < op2) ? 32'd1 : 32'd0;
      3'd4: return a ^ op2;
      3'd5: begin
        if (word[30]) return $signed(a) >>> op2[4:0];
        return a >> op2[4:0];
      end
      3'd6: return a | op2;
      default: return a & op2;
    endcase
  endfunction

  function automatic logic [31:0] r_word(logic [6:0] funct7, logic [2:0] funct3);
    return {funct7, 5'd2, 5'd1, funct3, 5'd3, rv32i_isa_pkg::reg_opcode};
  endfunction

  function automatic logic [31:0] i_word(logic [11:0] imm12, logic [2:0] funct3);
    return {imm12, 5'd1, funct3, 5'd3, rv32i_isa_pkg::imm_opcode};
  endfunction

  function automatic logic [31:0] u_word(logic [19:0] imm20, logic [6:0] opcode);
    return {imm20, 5'd3, opcode};
  endfunction

  function automatic logic [31:0] rand_word();
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    f3  = 3'($urandom_range(7));
    imm = 12'($urandom());
    alt = 1'($urandom_range(1));
    case ($urandom_range(3))
      0: return u_word(20'($urandom()), rv32i_isa_pkg::lui_opcode);
      1: return u_word(20'($urandom()), rv32i_isa_pkg::auipc_opcode);
      2: begin
        // shift immediates keep only shamt and the srai bit
        if (f3 == 3'd1 || f3 == 3'd5) imm[11:5] = {1'b0, alt & (f3 == 3'd5), 5'b0};
        return i_word(imm, f3);
      end
      default: return r_word({1'b0, alt & (f3 == 3'd0 || f3 == 3'd5), 5'b0}, f3);
    endcase
  endfunction

  function automatic ooo_pkg::src_t rand_rf();
    return make_src(1'($urandom_range(1)), $urandom(), 4'(8 + $urandom_range(7)));
  endfunction

  task automatic clear_cdb();
    for (int j = 0; j < cdb_size; j++) cdb_in[j] = '0;
  endtask

  task automatic drive_issue(logic [31:0] word, logic [31:0] pc, logic [3:0] target,
                             ooo_pkg::src_t s1_rf, ooo_pkg::src_t s2_rf,
                             ooo_pkg::src_t s1_rob, ooo_pkg::src_t s2_rob);
    issue.instr     = word;
    issue.pc        = pc;
    issue.target    = target;
    issue.rs1_rf    = s1_rf;
    issue.rs2_rf    = s2_rf;
    issue.rs1_rob   = s1_rob;
    issue.rs2_rob   = s2_rob;
    issue_valid     = 1'b1;
    exp_val[target] = model(word, pc, operand(s1_rf, s1_rob), operand(s2_rf, s2_rob));
    pending[target] = 1'b1;
  endtask

  task automatic send(logic [31:0] word, logic [31:0] pc, logic [3:0] target,
                      ooo_pkg::src_t s1_rf, ooo_pkg::src_t s2_rf,
                      ooo_pkg::src_t s1_rob, ooo_pkg::src_t s2_rob);
    drive_issue(word, pc, target, s1_rf, s2_rf, s1_rob, s2_rob);
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  task automatic wait_retired();
    int n;
    n = 0;
    while (pending != '0) begin
      if (n == wait_limit) fail_timeout("issued instructions to retire");
      n++;
      @(negedge clk);
    end
  endtask

  task automatic wait_full(logic level, string what);
    int n;
    n = 0;
    while (full !== level) begin
      if (n == wait_limit) fail_timeout(what);
      n++;
      @(negedge clk);
    end
  endtask

  // lone instruction with ready regfile operands and a result two edges later
  task automatic run_alone(logic [31:0] word);
    send(word, $urandom() & 32'hffff_fffc, 4'd0, make_src(1'b1, $urandom(), 4'd8),
         make_src(1'b1, $urandom(), 4'd9), make_src(1'b0, 32'h0, 4'd0),
         make_src(1'b0, 32'h0, 4'd0));
    @(negedge clk);
    check("result.valid", result.valid, 32'd1);
    check("result.tag", result.tag, 32'd0);
    wait_retired();
  endtask

  task automatic all_forms();
    run_alone(u_word(20'($urandom()), rv32i_isa_pkg::lui_opcode));
    run_alone(u_word(20'($urandom()), rv32i_isa_pkg::auipc_opcode));
    for (int f = 0; f < 8; f++) begin
      run_alone(i_word((f == 1 || f == 5) ? 12'($urandom_range(31)) : 12'($urandom()), 3'(f)));
      run_alone(r_word(7'b0, 3'(f)));
    end
    run_alone(i_word({7'b0100000, 5'($urandom())}, rv32i_isa_pkg::sr_funct3));
    run_alone(r_word(7'b0100000, rv32i_isa_pkg::add_funct3));
    run_alone(r_word(7'b0100000, rv32i_isa_pkg::sr_funct3));
  endtask

  task automatic source_priority();
    send(r_word(7'b0, rv32i_isa_pkg::add_funct3), 32'h0, 4'd1,
         make_src(1'b1, 32'd5, 4'd8), make_src(1'b1, 32'd7, 4'd9),
         make_src(1'b1, 32'd100, 4'd8), make_src(1'b1, 32'd200, 4'd9));
    wait_retired();
    send(r_word(7'b0, rv32i_isa_pkg::add_funct3), 32'h0, 4'd2,
         make_src(1'b0, 32'd5, 4'd8), make_src(1'b0, 32'd7, 4'd9),
         make_src(1'b1, 32'd100, 4'd8), make_src(1'b1, 32'd200, 4'd9));
    wait_retired();
  endtask

  task automatic cdb_wakeup();
    prod_val[8]  = $urandom();
    prod_val[9]  = $urandom();
    prod_val[10] = $urandom();
    send(r_word(7'b0100000, rv32i_isa_pkg::add_funct3), 32'h0, 4'd3,
         make_src(1'b0, 32'h0, 4'd8), make_src(1'b0, 32'h0, 4'd9),
         make_src(1'b0, 32'h0, 4'd0), make_src(1'b0, 32'h0, 4'd0));
    repeat (3) begin
      @(negedge clk);
      check("result.valid", result.valid, 32'd0);
    end
    cdb_in[0] = bcast(4'd8);
    @(negedge clk);
    clear_cdb();
    repeat (2) begin
      @(negedge clk);
      check("result.valid", result.valid, 32'd0);
    end
    cdb_in[1] = bcast(4'd9);
    @(negedge clk);
    clear_cdb();
    wait_retired();
    // broadcast in the issue cycle itself
    cdb_in[1] = bcast(4'd10);
    send(r_word(7'b0, rv32i_isa_pkg::xor_funct3), 32'h0, 4'd4,
         make_src(1'b0, 32'h0, 4'd10), make_src(1'b1, $urandom(), 4'd11),
         make_src(1'b0, 32'h0, 4'd0), make_src(1'b0, 32'h0, 4'd0));
    clear_cdb();
    wait_retired();
  endtask

  task automatic fill_and_drain();
    for (int t = 8; t < 16; t++) prod_val[t] = $urandom();
    for (int i = 0; i < n_entries; i++) begin
      send(r_word(7'b0, 3'($urandom_range(7))), 32'h0, 4'(i),
           make_src(1'b0, 32'h0, 4'(8 + $urandom_range(7))),
           make_src(1'b0, 32'h0, 4'(8 + $urandom_range(7))),
           make_src(1'b0, 32'h0, 4'd0), make_src(1'b0, 32'h0, 4'd0));
    end
    wait_full(1'b1, "full to rise");
    for (int t = 8; t < 16; t++) begin
      cdb_in[t % 2] = bcast(4'(t));
      @(negedge clk);
      clear_cdb();
    end
    wait_retired();
    wait_full(1'b0, "full to fall");
  endtask

  task automatic random_mix();
    int         issued;
    int         n;
    int         base;
    logic [3:0] target;
    logic       found;
    issued = 0;
    n = 0;
    for (int t = 8; t < 16; t++) prod_val[t] = $urandom();
    while (issued < 60) begin
      if (n == 2000) fail_timeout("the random stream to issue");
      n++;
      for (int j = 0; j < cdb_size; j++) begin
        if ($urandom_range(1)) cdb_in[j] = bcast(4'(8 + $urandom_range(7)));
        else cdb_in[j] = '0;
      end
      // pick a target tag that is not in flight
      found  = 1'b0;
      target = 4'd0;
      base   = $urandom_range(n_entries - 1);
      for (int k = 0; k < n_entries; k++) begin
        if (!found && !pending[(base + k) % n_entries]) begin
          found  = 1'b1;
          target = 4'((base + k) % n_entries);
        end
      end
      if (!full && found) begin
        drive_issue(rand_word(), $urandom() & 32'hffff_fffc, target, rand_rf(), rand_rf(),
                    make_src($urandom_range(3) == 0, $urandom(), 4'd0),
                    make_src($urandom_range(3) == 0, $urandom(), 4'd0));
        issued++;
      end else begin
        issue_valid = 1'b0;
      end
      @(negedge clk);
    end
    issue_valid = 1'b0;
    // drain with every producer tag in turn
    n = 0;
    while (pending != '0) begin
      if (n == wait_limit) fail_timeout("the random stream to drain");
      cdb_in[0] = bcast(4'(8 + n % 8));
      cdb_in[1] = '0;
      n++;
      @(negedge clk);
    end
    clear_cdb();
  endtask

  // result monitor against the scoreboard
  always @(negedge clk) begin
    if (!rst && result.valid) begin
      check("result.pending", pending[result.tag], 32'd1);
      check("result.value", result.value, exp_val[result.tag]);
      pending[result.tag] = 1'b0;
    end
  end

  initial begin
    void'($urandom(32'h36ea));
    clk         = 1'b0;
    rst         = 1'b1;
    issue_valid = 1'b0;
    issue       = '0;
    pending     = '0;
    clear_cdb();
    for (int t = 0; t < 16; t++) begin
      exp_val[t]  = '0;
      prod_val[t] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    all_forms();
    source_priority();
    cdb_wakeup();
    fill_and_drain();
    random_mix();
    @(negedge clk);
    if (pending == '0 && !full && !result.valid) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("instructions left in the unit at the end of the run");
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: list.f
rtl/rv32i_isa_pkg.sv
rtl/ooo_pkg.sv
rtl/alu_rs.sv
rtl/alu_exec.sv
rtl/alu_unit.sv
verif/alu_unit_assertions.sv
verif/alu_unit_tb.sv
